// ==== source/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

  // serial timing
  localparam int bit_cycles = 16;
  localparam int bit_cnt_w  = 5;
  localparam int frame_bits = 11;

  // command layout
  localparam int cmd_width = 16;
  localparam int rw_bit    = 15;

  // apb register offsets
  typedef enum logic [3:0] {
    reg_cmd     = 4'h0,
    reg_status  = 4'h4,
    reg_rx_data = 4'h8
  } reg_addr_e;

  // status register bits
  localparam int st_busy       = 0;
  localparam int st_rx_valid   = 1;
  localparam int st_parity_err = 2;

  typedef enum logic {
    tx_idle,
    tx_shift
  } tx_state_e;

  typedef enum logic [2:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_parity,
    rx_stop
  } rx_state_e;

  typedef enum logic [1:0] {
    fr_idle,
    fr_high,
    fr_low
  } framer_state_e;

endpackage

`default_nettype wire

// ==== source/apb_cmd_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module apb_cmd_regs
  import uart_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [3:0]           paddr,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [31:0]          pwdata,
  output logic [31:0]          prdata,
  output logic                 pready,
  output logic                 pslverr,
  output logic                 cmd_valid,
  output logic [cmd_width-1:0] cmd_data,
  input  logic                 cmd_ready,
  input  logic                 rx_byte_valid,
  input  logic [7:0]           rx_byte,
  input  logic                 rx_parity_ok
);

  reg_addr_e   addr;
  logic        access;
  logic        cmd_wr;
  logic        cmd_take;
  logic        rx_rd;
  logic        busy;
  logic        rx_valid;
  logic        parity_err;
  logic [7:0]  rx_data_q;
  logic [31:0] status;

  assign addr   = reg_addr_e'(paddr);
  assign access = psel & penable;

  // zero-wait slave
  assign pready = access;

  // a command still waiting for the framer counts as busy too
  assign busy     = ~cmd_ready | cmd_valid;
  assign cmd_wr   = access & pwrite & (addr == reg_cmd);
  assign cmd_take = cmd_wr & ~busy;
  assign pslverr  = cmd_wr & busy;
  assign rx_rd    = access & ~pwrite & (addr == reg_rx_data);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmd_valid <= 1'b0;
    end else if (cmd_take) begin
      cmd_valid <= 1'b1;
    end else if (cmd_ready) begin
      cmd_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_take) begin
      cmd_data <= pwdata[cmd_width-1:0];
    end
  end

  // new byte wins over a read in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_valid   <= 1'b0;
      parity_err <= 1'b0;
      rx_data_q  <= 8'h00;
    end else if (rx_byte_valid) begin
      rx_valid   <= 1'b1;
      parity_err <= ~rx_parity_ok;
      rx_data_q  <= rx_byte;
    end else if (rx_rd) begin
      rx_valid   <= 1'b0;
      parity_err <= 1'b0;
    end
  end

  always_comb begin
    status                = '0;
    status[st_busy]       = busy;
    status[st_rx_valid]   = rx_valid;
    status[st_parity_err] = parity_err;
  end

  // read mux, unknown offsets give zero
  always_comb begin
    case (addr)
      reg_status:  prdata = status;
      reg_rx_data: prdata = {24'h000000, rx_data_q};
      default:     prdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/cmd_framer.sv ====
`timescale 1ns/1ns
`default_nettype none

module cmd_framer
  import uart_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 cmd_valid,
  input  logic [cmd_width-1:0] cmd_data,
  output logic                 cmd_ready,
  output logic                 byte_valid,
  output logic [7:0]           byte_data,
  input  logic                 byte_ready
);

  framer_state_e        state;
  logic [cmd_width-1:0] cmd_q;
  logic                 cmd_fire;
  logic                 byte_fire;

  // only take a command once the transmitter is free as well
  assign cmd_ready = (state == fr_idle) & byte_ready;
  assign cmd_fire  = cmd_valid & cmd_ready;
  assign byte_fire = byte_valid & byte_ready;

  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      cmd_q <= cmd_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= fr_idle;
    end else begin
      case (state)
        fr_idle: begin
          if (cmd_fire) begin
            state <= fr_high;
          end
        end
        fr_high: begin
          // reads stop after the address byte
          if (byte_fire) begin
            state <= cmd_q[rw_bit] ? fr_low : fr_idle;
          end
        end
        fr_low: begin
          if (byte_fire) begin
            state <= fr_idle;
          end
        end
        default: state <= fr_idle;
      endcase
    end
  end

  assign byte_valid = (state != fr_idle);

  always_comb begin
    if (state == fr_low) begin
      byte_data = cmd_q[7:0];
    end else begin
      byte_data = cmd_q[15:8];
    end
  end

endmodule

`default_nettype wire

// ==== source/uart_tx.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_tx
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       byte_valid,
  input  logic [7:0] byte_data,
  output logic       byte_ready,
  output logic       tx
);

  tx_state_e                 state;
  logic [frame_bits-1:0]     frame_q;
  logic [bit_cnt_w-1:0]      bit_cnt;
  logic [3:0]                bit_idx;
  logic                      bit_end;
  logic                      last_bit;

  assign byte_ready = (state == tx_idle);
  assign bit_end    = (bit_cnt == bit_cnt_w'(bit_cycles - 1));
  assign last_bit   = (bit_idx == 4'(frame_bits - 1));

  // line follows bit 0 of the frame, all ones when idle
  assign tx = frame_q[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= tx_idle;
      frame_q <= '1;
      bit_cnt <= '0;
      bit_idx <= '0;
    end else begin
      case (state)
        tx_idle: begin
          if (byte_valid) begin
            // stop, odd parity, data, start
            frame_q <= {1'b1, ~^byte_data, byte_data, 1'b0};
            bit_cnt <= '0;
            bit_idx <= '0;
            state   <= tx_shift;
          end
        end
        tx_shift: begin
          if (bit_end) begin
            bit_cnt <= '0;
            if (last_bit) begin
              state <= tx_idle;
            end else begin
              frame_q <= {1'b1, frame_q[frame_bits-1:1]};
              bit_idx <= bit_idx + 4'd1;
            end
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        default: state <= tx_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/uart_rx.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_rx
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  output logic       rx_byte_valid,
  output logic [7:0] rx_byte,
  output logic       rx_parity_ok
);

  rx_state_e            state;
  logic                 rx_s1;
  logic                 rx_s2;
  logic                 rx_prev;
  logic                 fall;
  logic [bit_cnt_w-1:0] bit_cnt;
  logic [2:0]           bit_idx;
  logic                 parity_q;
  logic                 half_bit;
  logic                 full_bit;

  // two-flop synchronizer plus one stage for edge detect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_s1   <= 1'b1;
      rx_s2   <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_s1   <= rx;
      rx_s2   <= rx_s1;
      rx_prev <= rx_s2;
    end
  end

  assign fall     = rx_prev & ~rx_s2;
  assign half_bit = (bit_cnt == bit_cnt_w'(bit_cycles / 2 - 1));
  assign full_bit = (bit_cnt == bit_cnt_w'(bit_cycles - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= rx_idle;
      bit_cnt       <= '0;
      bit_idx       <= '0;
      rx_byte_valid <= 1'b0;
    end else begin
      rx_byte_valid <= 1'b0;
      bit_cnt       <= bit_cnt + 1'b1;
      case (state)
        rx_idle: begin
          bit_cnt <= '0;
          if (fall) begin
            state <= rx_start;
          end
        end
        rx_start: begin
          // glitch shorter than half a bit is dropped
          if (half_bit) begin
            bit_cnt <= '0;
            bit_idx <= '0;
            state   <= rx_s2 ? rx_idle : rx_data;
          end
        end
        rx_data: begin
          if (full_bit) begin
            bit_cnt <= '0;
            bit_idx <= bit_idx + 3'd1;
            if (bit_idx == 3'd7) begin
              state <= rx_parity;
            end
          end
        end
        rx_parity: begin
          if (full_bit) begin
            bit_cnt <= '0;
            state   <= rx_stop;
          end
        end
        rx_stop: begin
          // stop level itself is not checked
          if (full_bit) begin
            rx_byte_valid <= 1'b1;
            state         <= rx_idle;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

  // data and parity capture
  always_ff @(posedge clk) begin
    if (state == rx_data && full_bit) begin
      rx_byte <= {rx_s2, rx_byte[7:1]};
    end
    if (state == rx_parity && full_bit) begin
      parity_q <= rx_s2;
    end
    if (state == rx_stop && full_bit) begin
      rx_parity_ok <= ^{rx_byte, parity_q};
    end
  end

endmodule

`default_nettype wire

// ==== source/uart_bridge_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_bridge_top
  import uart_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic [3:0]  paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  input  logic        rx,
  output logic        tx
);

  logic                 cmd_valid;
  logic                 cmd_ready;
  logic [cmd_width-1:0] cmd_data;
  logic                 byte_valid;
  logic                 byte_ready;
  logic [7:0]           byte_data;
  logic                 rx_byte_valid;
  logic [7:0]           rx_byte;
  logic                 rx_parity_ok;

  apb_cmd_regs apb_cmd_regs_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .paddr         (paddr),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .cmd_valid     (cmd_valid),
    .cmd_data      (cmd_data),
    .cmd_ready     (cmd_ready),
    .rx_byte_valid (rx_byte_valid),
    .rx_byte       (rx_byte),
    .rx_parity_ok  (rx_parity_ok)
  );

  cmd_framer cmd_framer_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd_data   (cmd_data),
    .cmd_ready  (cmd_ready),
    .byte_valid (byte_valid),
    .byte_data  (byte_data),
    .byte_ready (byte_ready)
  );

  uart_tx uart_tx_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .byte_valid (byte_valid),
    .byte_data  (byte_data),
    .byte_ready (byte_ready),
    .tx         (tx)
  );

  // answers come back on rx
  uart_rx uart_rx_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx            (rx),
    .rx_byte_valid (rx_byte_valid),
    .rx_byte       (rx_byte),
    .rx_parity_ok  (rx_parity_ok)
  );

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  // reset held for the first eight cycles
  initial begin
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== tests/uart_bridge_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_bridge_assert
  import uart_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input logic [3:0] paddr,
  input logic       psel,
  input logic       penable,
  input logic       pwrite,
  input logic       pslverr,
  input logic       tx,
  input tx_state_e  tx_state,
  input logic       rx_byte_valid
);

  // idle transmitter holds the line at stop level
  tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
    (tx_state == tx_idle) |-> tx)
    else $error("tx low while uart_tx is idle");

  // a command write while a frame is on the line is refused
  slverr_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (psel && penable && pwrite && (paddr == reg_cmd) && (tx_state != tx_idle)) |-> pslverr)
    else $error("command write during a frame got no pslverr");

  rx_pulse_single: assert property (@(posedge clk) disable iff (!rst_n)
    rx_byte_valid |=> !rx_byte_valid)
    else $error("rx_byte_valid high for more than one cycle");

endmodule

bind uart_bridge_top uart_bridge_assert uart_bridge_assert_i (
  .clk           (clk),
  .rst_n         (rst_n),
  .paddr         (paddr),
  .psel          (psel),
  .penable       (penable),
  .pwrite        (pwrite),
  .pslverr       (pslverr),
  .tx            (tx),
  .tx_state      (uart_tx_i.state),
  .rx_byte_valid (rx_byte_valid)
);

`default_nettype wire

// ==== tests/uart_bridge_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_bridge_tb
  import uart_pkg::*;
();

  logic        clk;
  logic        rst_n;
  logic [3:0]  paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        rx;
  logic        tx;
  logic        loopback;
  logic        drv_line;
  logic [7:0]  mon_q[$];
  int          mon_rd;
  int          mon_cnt;
  logic        mon_busy;
  logic [10:0] mon_bits;
  logic [31:0] rd;
  logic        err;

  tb_clock_gen tb_clock_gen_i (.clk(clk), .rst_n(rst_n));

  uart_bridge_top uart_bridge_top_i (.*);

  // rx from our own tx or from the line driver
  assign rx = loopback ? tx : drv_line;

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("FAIL: see errors above");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else
      abort_run($sformatf("FAIL at %0t ns: %s is %08h, expected %08h", $time, what, got, exp));
  endtask

  task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata);
    int waited;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      assert (waited < 8) else abort_run("APB access timed out, pready never rose");
    end while (!pready);
    rd      = prdata;
    err     = pslverr;
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic read_expect(input logic [3:0] addr, input string what, input logic [31:0] exp);
    apb_access(1'b0, addr, '0);
    expect_eq(what, rd, exp);
  endtask

  // poll STATUS until the masked bits reach the wanted level
  task automatic wait_status(input logic [31:0] mask, input logic level, input string what);
    int polls;
    polls = 0;
    do begin
      apb_access(1'b0, reg_status, '0);
      polls++;
      assert (polls < 200) else abort_run({"timeout waiting for ", what});
    end while (((rd & mask) != 0) != level);
  endtask

  task automatic expect_frame(input logic [7:0] exp);
    assert (mon_q.size() > mon_rd) else
      abort_run("serial monitor saw fewer frames than expected");
    expect_eq("serial frame byte", {24'h0, mon_q[mon_rd]}, {24'h0, exp});
    mon_rd++;
  endtask

  task automatic check_frame(input logic [10:0] frame);
    assert (frame[0] == 1'b0 && frame[10] == 1'b1) else
      abort_run($sformatf("FAIL at %0t ns: frame %03h has bad start or stop", $time, frame));
    assert (^frame[9:1] == 1'b1) else
      abort_run($sformatf("FAIL at %0t ns: frame %03h has even parity", $time, frame));
    mon_q.push_back(frame[8:1]);
  endtask

  task automatic send_serial(input logic [7:0] data, input logic par);
    logic [10:0] frame;
    frame = {1'b1, par, data, 1'b0};
    repeat (frame_bits) begin
      @(posedge clk);
      drv_line <= frame[0];
      frame = frame >> 1;
      repeat (bit_cycles - 1) @(posedge clk);
    end
  endtask

  // STATUS: busy 0x1, rx_valid 0x2, parity_err 0x4
  task automatic run_command(input logic [15:0] cmd);
    apb_access(1'b0, reg_rx_data, '0);
    apb_access(1'b1, reg_cmd, {16'h0000, cmd});
    expect_eq("pslverr on idle command", {31'b0, err}, 32'h0);
    read_expect(reg_status, "STATUS while sending", 32'h1);
    wait_status(32'h1, 1'b0, "busy to clear");
    expect_frame(cmd[15:8]);
    if (cmd[rw_bit]) begin
      expect_frame(cmd[7:0]);
    end
    expect_eq("frames seen", mon_q.size(), mon_rd);
    read_expect(reg_status, "STATUS after command", 32'h2);
    read_expect(reg_rx_data, "RX_DATA", {24'h0, cmd[rw_bit] ? cmd[7:0] : cmd[15:8]});
    read_expect(reg_status, "STATUS after RX_DATA read", 32'h0);
  endtask

  // serial monitor, samples tx at mid-bit
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mon_busy <= 1'b0;
      mon_cnt  <= 0;
    end else if (!mon_busy) begin
      if (!tx) begin
        mon_busy <= 1'b1;
        mon_cnt  <= 1;
      end
    end else begin
      mon_cnt <= mon_cnt + 1;
      if (mon_cnt % bit_cycles == bit_cycles / 2 - 1) begin
        mon_bits <= {tx, mon_bits[10:1]};
      end
      if (mon_cnt == frame_bits * bit_cycles - bit_cycles / 2 - 1) begin
        mon_busy <= 1'b0;
        check_frame({tx, mon_bits[10:1]});
      end
    end
  end

  initial begin
    int waited;
    void'($urandom(32'h40fd_9a85));
    psel     <= 1'b0;
    penable  <= 1'b0;
    pwrite   <= 1'b0;
    paddr    <= '0;
    pwdata   <= '0;
    loopback <= 1'b1;
    drv_line <= 1'b1;
    mon_rd   = 0;
    waited   = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      waited++;
      assert (waited < 64) else abort_run("reset was never released");
    end

    expect_eq("tx after reset", {31'b0, tx}, 32'h1);
    read_expect(reg_status, "STATUS after reset", 32'h0);
    read_expect(reg_rx_data, "RX_DATA after reset", 32'h0);

    // one write and one read in loopback
    run_command(16'ha53c);
    run_command(16'h2f00);

    // second command while the first is on the line
    apb_access(1'b1, reg_cmd, 32'h0000_c381);
    expect_eq("pslverr on idle command", {31'b0, err}, 32'h0);
    apb_access(1'b1, reg_cmd, 32'h0000_9944);
    expect_eq("pslverr on busy command", {31'b0, err}, 32'h1);
    apb_access(1'b0, reg_status, '0);
    expect_eq("STATUS busy bit", rd & 32'h1, 32'h1);
    wait_status(32'h1, 1'b0, "busy to clear");
    expect_frame(8'hc3);
    expect_frame(8'h81);
    expect_eq("frames after dropped command", mon_q.size(), mon_rd);

    // external line, 0x3c with even parity then 0x3d with odd
    @(posedge clk);
    loopback <= 1'b0;
    apb_access(1'b0, reg_rx_data, '0);
    send_serial(8'h3c, 1'b0);
    wait_status(32'h2, 1'b1, "a received byte");
    read_expect(reg_status, "STATUS after bad parity", 32'h6);
    read_expect(reg_rx_data, "RX_DATA after bad parity", 32'h3c);
    send_serial(8'h3d, 1'b0);
    wait_status(32'h2, 1'b1, "a received byte");
    read_expect(reg_status, "STATUS after good parity", 32'h2);
    read_expect(reg_rx_data, "RX_DATA after good parity", 32'h3d);
    read_expect(reg_status, "STATUS after RX_DATA read", 32'h0);
    @(posedge clk);
    loopback <= 1'b1;

    for (int n = 0; n < 20; n++) begin
      run_command(16'($urandom));
    end
    expect_eq("frames at end of run", mon_q.size(), mon_rd);
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
source/uart_pkg.sv
source/apb_cmd_regs.sv
source/cmd_framer.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_bridge_top.sv
tests/tb_clock_gen.sv
tests/uart_bridge_assert.sv
tests/uart_bridge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module uart_bridge_tb -Mdir obj_dir -o uart_bridge_sim -f build.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/uart_bridge_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "testbench reported failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
echo "testbench passed"
exit 0
